// ==== Makefile ====
# Verilator flow for the nn_top testbench
# any variable can be set on the command line, e.g. make sim OBJ_DIR=build

VERILATOR   ?= verilator
TOP         ?= nn_tb
FLIST       ?= tb.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert
LINT_FLAGS  ?= --lint-only
BUILD_FLAGS ?= --binary -j 0

.PHONY: all lint build sim clean

all: sim

# static checks only
lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# compile the testbench and DUT into one executable
build:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# exit status follows the testbench result
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/dense_layer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dense_layer #(
	parameter int N_X  = 4,
	parameter int N_Y  = 3,
	parameter bit RELU = 1'b1
) (
	input  logic          clk,
	input  logic          rst_n,
	// serial weight load
	input  logic          w_valid,
	input  nn_pkg::data_t w_word,
	// input vector
	input  logic          x_valid,
	input  nn_pkg::data_t x [N_X],
	// output vector, zero when not valid
	output logic          y_valid,
	output nn_pkg::data_t y [N_Y]
);
	import nn_pkg::*;

	// weight of input i into neuron j sits at j*N_X+i
	data_t w    [N_X*N_Y];
	// stage 1 scaled products, same layout as w
	data_t prod [N_X*N_Y];
	logic  p_valid;
	// stage 2 combinational results
	data_t sum  [N_Y];
	data_t act  [N_Y];

	// balanced tree of pairs over one neuron's row
	// odd leftover passes up a level unchanged
	function automatic data_t row_sum(input data_t p [N_X*N_Y], input int j);
		data_t t [N_X];
		int    n;
		for (int i = 0; i < N_X; i++)
			t[i] = p[j*N_X+i];
		n = N_X;
		// N_X levels always enough, extra ones leave t[0] alone
		for (int lvl = 0; lvl < N_X; lvl++) begin
			for (int i = 0; i < N_X; i++) begin
				if (2*i + 1 < n)
					t[i] = fx_add(t[2*i], t[2*i+1]);
				else if (2*i < n)
					t[i] = t[2*i];
			end
			n = (n + 1) / 2;
		end
		return t[0];
	endfunction

	// ========================================
	// weight shift register
	// ========================================

	// newest word at the top, first word drifts to index 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < N_X*N_Y; k++)
				w[k] <= '0;
		end else if (w_valid) begin
			w[N_X*N_Y-1] <= w_word;
			for (int k = 0; k < N_X*N_Y - 1; k++)
				w[k] <= w[k+1];
		end
	end

	// ========================================
	// stage 1: multiply
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			p_valid <= 1'b0;
		else
			p_valid <= x_valid;
	end

	// every input feeds every neuron
	always_ff @(posedge clk) begin
		if (x_valid) begin
			for (int j = 0; j < N_Y; j++) begin
				for (int i = 0; i < N_X; i++)
					prod[j*N_X+i] <= fx_mul(w[j*N_X+i], x[i]);
			end
		end
	end

	// ========================================
	// stage 2: adder tree and ReLU
	// ========================================

	always_comb begin
		for (int j = 0; j < N_Y; j++) begin
			sum[j] = row_sum(prod, j);
			act[j] = RELU ? fx_relu(sum[j]) : sum[j];
		end
	end

	// output forced to zero outside the valid cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			y_valid <= 1'b0;
			for (int j = 0; j < N_Y; j++)
				y[j] <= '0;
		end else begin
			y_valid <= p_valid;
			for (int j = 0; j < N_Y; j++)
				y[j] <= p_valid ? act[j] : data_t'(0);
		end
	end

	// ========================================
	// checks
	// ========================================

	// no weight load while a point is anywhere in this layer
	a_no_load_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
		w_valid |-> !(x_valid || p_valid || y_valid));

	for (genvar j = 0; j < N_Y; j++) begin : g_zero_chk
		a_y_zero: assert property (@(posedge clk) disable iff (!rst_n)
			!y_valid |-> (y[j] == '0));
	end

endmodule

`default_nettype wire

// ==== rtl/input_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module input_loader (
	input  logic          clk,
	input  logic          rst_n,
	// serial data-point words
	input  logic          in_valid,
	input  nn_pkg::data_t word,
	// one full point
	output logic          x_valid,
	output nn_pkg::data_t x [nn_pkg::N_IN]
);
	import nn_pkg::*;

	// words of the point still being collected
	data_t            sh [N_IN];
	logic [CNT_W-1:0] cnt;
	logic             last_word;

	assign last_word = in_valid && (cnt == CNT_W'(N_IN - 1));

	// ========================================
	// word counter and point strobe
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt     <= '0;
			x_valid <= 1'b0;
		end else begin
			x_valid <= last_word;
			// gaps between words just hold the count
			if (last_word)
				cnt <= '0;
			else if (in_valid)
				cnt <= cnt + 1'b1;
		end
	end

	// ========================================
	// shift in with the newest at the top
	// ========================================

	// first word ends up in element 0
	always_ff @(posedge clk) begin
		if (in_valid) begin
			sh[N_IN-1] <= word;
			for (int i = 0; i < N_IN - 1; i++)
				sh[i] <= sh[i+1];
		end
	end

	// x only moves when a point completes
	always_ff @(posedge clk) begin
		if (last_word) begin
			x[N_IN-1] <= word;
			for (int i = 0; i < N_IN - 1; i++)
				x[i] <= sh[i+1];
		end
	end

	// counter wraps before reaching N_IN
	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		cnt <= CNT_W'(N_IN - 1));

endmodule

`default_nettype wire

// ==== rtl/nn_pkg.sv ====
`default_nettype none

package nn_pkg;

	// ========================================
	// fixed-point format
	// ========================================

	// one word per activation or weight
	localparam int DATA_W    = 16;
	// Q8.8
	localparam int FRAC_BITS = 8;

	// ========================================
	// network sizes
	// ========================================

	localparam int N_IN  = 4;
	localparam int N_HID = 3;
	localparam int N_OUT = 1;

	// word counter in the loader
	localparam int CNT_W = $clog2(N_IN);

	// ========================================
	// element types
	// ========================================

	typedef logic signed [DATA_W-1:0]   data_t;
	// full product before scaling back
	typedef logic signed [2*DATA_W-1:0] prod_t;

	// ========================================
	// arithmetic
	// ========================================

	// full product, arithmetic shift by FRAC_BITS, low DATA_W bits kept
	function automatic data_t fx_mul(input data_t a, input data_t b);
		prod_t p;
		p = prod_t'(a) * prod_t'(b);
		return data_t'(p >>> FRAC_BITS);
	endfunction

	// plain two's-complement wrap, no saturation
	function automatic data_t fx_add(input data_t a, input data_t b);
		return a + b;
	endfunction

	// negative clamps to zero
	function automatic data_t fx_relu(input data_t s);
		return s[DATA_W-1] ? data_t'(0) : s;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/nn_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module nn_top (
	input  logic          clk,
	input  logic          rst_n,
	// data point, one word per strobe
	input  logic          in_valid_d,
	input  nn_pkg::data_t data_point,
	// hidden-layer weights
	input  logic          in_valid_w1,
	input  nn_pkg::data_t weight1,
	// output-layer weights
	input  logic          in_valid_w2,
	input  nn_pkg::data_t weight2,
	// network result
	output logic          out_valid,
	output nn_pkg::data_t out
);
	import nn_pkg::*;

	// ========================================
	// links between stages
	// ========================================

	// loader to hidden layer
	logic  x_valid;
	data_t x  [N_IN];
	// hidden to output layer
	logic  h_valid;
	data_t h  [N_HID];
	// output layer result vector
	data_t y2 [N_OUT];

	// ========================================
	// data-point loader
	// ========================================

	input_loader u_loader (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid_d),
		.word     (data_point),
		.x_valid  (x_valid),
		.x        (x)
	);

	// ========================================
	// hidden layer, ReLU on
	// ========================================

	dense_layer #(
		.N_X  (N_IN),
		.N_Y  (N_HID),
		.RELU (1'b1)
	) u_hidden (
		.clk     (clk),
		.rst_n   (rst_n),
		.w_valid (in_valid_w1),
		.w_word  (weight1),
		.x_valid (x_valid),
		.x       (x),
		.y_valid (h_valid),
		.y       (h)
	);

	// ========================================
	// output layer, linear
	// ========================================

	dense_layer #(
		.N_X  (N_HID),
		.N_Y  (N_OUT),
		.RELU (1'b0)
	) u_output (
		.clk     (clk),
		.rst_n   (rst_n),
		.w_valid (in_valid_w2),
		.w_word  (weight2),
		.x_valid (h_valid),
		.x       (h),
		.y_valid (out_valid),
		.y       (y2)
	);

	// single output neuron
	assign out = y2[0];

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/nn_pkg.sv
rtl/input_loader.sv
rtl/dense_layer.sv
rtl/nn_top.sv
tb/clk_rst_gen.sv
tb/nn_tb.sv

// ==== tb/clk_rst_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clk_rst_gen #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	// free-running clock, starts low
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// active-low reset held for RST_CYCLES rising edges
	// release lands just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/nn_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module nn_tb;
	import nn_pkg::*;

	// ========================================
	// run constants
	// ========================================

	localparam int CLK_PERIOD     = 8;
	localparam int RST_CYCLES     = 8;
	localparam int DRIVE_DELAY    = 1;
	localparam int SEED           = 71;
	// last word sampled one edge on and the result 4 edges later
	localparam int OUT_DELAY      = 5;
	localparam int N_ROWS         = 8;
	localparam int N_W1           = N_IN * N_HID;
	localparam int N_W2           = N_HID * N_OUT;
	// worst row is drain, full reload and four gapped words
	localparam int CYCLES_PER_ROW = 40;
	localparam int WATCHDOG_NS    = (N_ROWS * CYCLES_PER_ROW + RST_CYCLES) * CLK_PERIOD;

	logic  clk;
	logic  rst_n;
	logic  in_valid_d;
	data_t data_point;
	logic  in_valid_w1;
	data_t weight1;
	logic  in_valid_w2;
	data_t weight2;
	logic  out_valid;
	data_t out;

	// rising edges since time zero
	int    cycle_cnt;
	// expected results in arrival order with the cycle each is due
	data_t exp_q [$];
	int    due_q [$];

	// ========================================
	// stimulus table
	// ========================================

	// hidden weights in neuron-major order with index 0 sent first
	data_t tbl_w1 [N_ROWS][N_W1] = '{
		'{16'h0100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0100,
		  16'h0000, 16'h0000, 16'h0080, 16'h0080, 16'h0080, 16'h0080},
		'{16'h0100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0100,
		  16'h0000, 16'h0000, 16'h0080, 16'h0080, 16'h0080, 16'h0080},
		'{16'h0100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0100,
		  16'h0000, 16'h0000, 16'h0080, 16'h0080, 16'h0080, 16'h0080},
		'{16'h0100, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0100,
		  16'h0000, 16'h0000, 16'h0080, 16'h0080, 16'h0080, 16'h0080},
		'{16'h6400, 16'h6400, 16'h6400, 16'h0000, 16'h0000, 16'h0000,
		  16'h0000, 16'h4000, 16'h0000, 16'h0000, 16'h0000, 16'h0100},
		'{16'h6400, 16'h6400, 16'h6400, 16'h0000, 16'h0000, 16'h0000,
		  16'h0000, 16'h4000, 16'h0000, 16'h0000, 16'h0000, 16'h0100},
		'{16'h0180, 16'hFF80, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		  16'h0001, 16'h0000, 16'hFE00, 16'h0000, 16'h0000, 16'h0300},
		'{16'h0180, 16'hFF80, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		  16'h0001, 16'h0000, 16'hFE00, 16'h0000, 16'h0000, 16'h0300}
	};

	// one output weight per hidden neuron
	data_t tbl_w2 [N_ROWS][N_W2] = '{
		'{16'h0100, 16'h0200, 16'h0080},
		'{16'h0100, 16'h0200, 16'h0080},
		'{16'h0100, 16'h0200, 16'h0080},
		'{16'h0100, 16'h0200, 16'h0080},
		'{16'h0100, 16'h0200, 16'hFF00},
		'{16'h0100, 16'h0200, 16'hFF00},
		'{16'hFF40, 16'h7FFF, 16'h0080},
		'{16'hFF40, 16'h7FFF, 16'h0080}
	};

	// data points with element 0 sent first
	data_t tbl_x [N_ROWS][N_IN] = '{
		'{16'h0100, 16'h0200, 16'h0300, 16'h0400},
		'{16'h0040, 16'h0080, 16'h0100, 16'h0200},
		// hidden neuron 0 clamps
		'{16'hFF00, 16'h0300, 16'h0080, 16'h0000},
		// every hidden neuron clamps
		'{16'hFE00, 16'hFF00, 16'hFF80, 16'hFFC0},
		// wrapping sums and products
		'{16'h0100, 16'h0100, 16'h0100, 16'h0500},
		'{16'h0080, 16'h0080, 16'h0080, 16'h0100},
		// fractional products truncate toward minus infinity
		'{16'h0203, 16'h0101, 16'h0080, 16'h0355},
		'{16'h0100, 16'h0000, 16'h0000, 16'h0100}
	};

	data_t tbl_exp [N_ROWS] = '{
		16'h0780, 16'h0230, 16'h06A0, 16'h0000,
		16'hA700, 16'h7F00, 16'h0119, 16'hFF60
	};

	// 1 = random idle cycles before each word, 0 = consecutive words
	bit tbl_gap [N_ROWS] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};

	// ========================================
	// clock, reset and DUT
	// ========================================

	clk_rst_gen #(
		.PERIOD_NS  (CLK_PERIOD),
		.RST_CYCLES (RST_CYCLES)
	) u_clk_rst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	nn_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_d  (in_valid_d),
		.data_point  (data_point),
		.in_valid_w1 (in_valid_w1),
		.weight1     (weight1),
		.in_valid_w2 (in_valid_w2),
		.weight2     (weight2),
		.out_valid   (out_valid),
		.out         (out)
	);

	// ========================================
	// reference model
	// ========================================

	// Q8.8 product as the middle DATA_W bits of the full product
	function automatic data_t q_mul(input data_t a, input data_t b);
		prod_t full;
		full = prod_t'(a) * prod_t'(b);
		return full[FRAC_BITS +: DATA_W];
	endfunction

	// forward pass of one table row with sums wrapping at DATA_W bits
	function automatic data_t ref_out(input int r);
		data_t hid [N_HID];
		data_t acc;
		for (int j = 0; j < N_HID; j++) begin
			acc = '0;
			for (int i = 0; i < N_IN; i++)
				acc = acc + q_mul(tbl_w1[r][j*N_IN+i], tbl_x[r][i]);
			// ReLU
			hid[j] = (acc < 0) ? data_t'(0) : acc;
		end
		acc = '0;
		for (int k = 0; k < N_HID; k++)
			acc = acc + q_mul(tbl_w2[r][k], hid[k]);
		return acc;
	endfunction

	// new weights needed on the first row and on any change
	function automatic bit needs_reload(input int r);
		bit diff;
		diff = (r == 0);
		if (r > 0) begin
			for (int k = 0; k < N_W1; k++)
				diff |= (tbl_w1[r][k] != tbl_w1[r-1][k]);
			for (int k = 0; k < N_W2; k++)
				diff |= (tbl_w2[r][k] != tbl_w2[r-1][k]);
		end
		return diff;
	endfunction

	// ========================================
	// failure and compare tasks
	// ========================================

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_out(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	// hand values against the model before any stimulus
	task automatic check_table();
		for (int r = 0; r < N_ROWS; r++) begin
			if (ref_out(r) != tbl_exp[r])
				stop_run($sformatf(
					"table row %0d holds an expected output the reference model disagrees with",
					r));
		end
	endtask

	// ========================================
	// drive tasks
	// ========================================

	// inputs change a fixed delay after the rising edge
	task automatic step();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic drive_idle();
		step();
		in_valid_d  = 1'b0;
		in_valid_w1 = 1'b0;
		in_valid_w2 = 1'b0;
	endtask

	// both weight sets shift in together
	task automatic load_weights(input int r);
		for (int k = 0; k < N_W1; k++) begin
			step();
			in_valid_d  = 1'b0;
			in_valid_w1 = 1'b1;
			weight1     = tbl_w1[r][k];
			in_valid_w2 = 1'b0;
			if (k < N_W2) begin
				in_valid_w2 = 1'b1;
				weight2     = tbl_w2[r][k];
			end
		end
		drive_idle();
	endtask

	// expected value queued as the last word goes out
	task automatic send_point(input int r);
		int gap;
		for (int i = 0; i < N_IN; i++) begin
			gap = tbl_gap[r] ? int'($urandom % 4) : 0;
			repeat (gap) drive_idle();
			step();
			in_valid_d = 1'b1;
			data_point = tbl_x[r][i];
			if (i == N_IN - 1) begin
				exp_q.push_back(tbl_exp[r]);
				due_q.push_back(cycle_cnt + OUT_DELAY);
			end
		end
	endtask

	// wait for an empty pipeline before touching weights
	task automatic drain();
		drive_idle();
		while (due_q.size() != 0)
			drive_idle();
		drive_idle();
	endtask

	// ========================================
	// monitor
	// ========================================

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// sampled mid-cycle away from both edges
	always @(negedge clk) begin
		if (rst_n) begin
			if (due_q.size() != 0 && due_q[0] == cycle_cnt) begin
				check_valid("out_valid", out_valid, 1'b1);
				check_out("out", out, exp_q[0]);
				exp_q.delete(0);
				due_q.delete(0);
			end else begin
				// idle cycles read zero
				check_valid("out_valid", out_valid, 1'b0);
				check_out("out", out, data_t'(0));
			end
		end
	end

	// ========================================
	// watchdog
	// ========================================

	initial begin
		#(WATCHDOG_NS);
		stop_run("timeout: the test did not finish in the allowed time");
	end

	// ========================================
	// main sequence
	// ========================================

	initial begin
		void'($urandom(SEED));
		cycle_cnt   = 0;
		in_valid_d  = 1'b0;
		data_point  = '0;
		in_valid_w1 = 1'b0;
		weight1     = '0;
		in_valid_w2 = 1'b0;
		weight2     = '0;

		check_table();
		wait (rst_n === 1'b1);

		for (int r = 0; r < N_ROWS; r++) begin
			if (needs_reload(r)) begin
				drain();
				load_weights(r);
			end
			send_point(r);
		end

		drain();
		// a few more quiet cycles on the output
		repeat (4) drive_idle();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
